/* project.f */
+incdir+include
logic/cpuBusPkg.sv
logic/instructionPhaseDecoder.sv
logic/busController.sv
logic/cpuBusTop.sv
test/cpuBusTop_assert.sv
test/cpuBusTop_tb.sv

/* test/cpuBusTop_tb.sv */
`include "cpuBus_macros.svh"

module cpuBusTop_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD    = 10;
	localparam int RESET_CYCLES  = 10;
	localparam int NUM_ROWS      = 12;
	localparam int PHASE_COUNT   = 4;
	localparam int HALT_CYCLES   = PHASE_COUNT + 6;
	localparam int STEP_LIMIT    = 2 * PHASE_COUNT + 2;   // Cycles allowed for one step ack
	localparam int DEBUG_CYCLES  = 2 * (STEP_LIMIT + 4) + 4;
	localparam int MARGIN_CYCLES = 50;
	localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_ROWS * PHASE_COUNT + HALT_CYCLES +
		DEBUG_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		cpuBusPkg::addrSelE addrSel;
		cpuBusPkg::dataSelE dataSel;
		logic               isByte;
		cpuBusPkg::busSeqE  seq;
		logic               addrLsb;   // Forced onto the selected address
		logic [2:0]         strobes;   // Commit {rdN, wrN0, wrN1}
	} rowS;

	logic                   clk;
	logic                   arstN;
	logic                   halt;
	cpuBusPkg::debugCtlS    debug;
	logic [`CPU_WORD_W-1:0] din;
	cpuBusPkg::busCmdS      cmd;
	cpuBusPkg::datapathS    datapath;
	cpuBusPkg::memBusS      mem;
	logic [`CPU_WORD_W-1:0] instruction;
	cpuBusPkg::phaseE       phase;
	logic                   pcEn;
	logic                   stopped;
	logic                   debugActive;
	logic                   stepAck;

	integer seed = 91362;
	rowS    stimTable [NUM_ROWS];

	cpuBusTop dut_i (
		.clk         (clk),
		.arstN       (arstN),
		.halt        (halt),
		.debug       (debug),
		.din         (din),
		.cmd         (cmd),
		.datapath    (datapath),
		.mem         (mem),
		.instruction (instruction),
		.phase       (phase),
		.pcEn        (pcEn),
		.stopped     (stopped),
		.debugActive (debugActive),
		.stepAck     (stepAck)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t before all tests finished", $time);
		$display("test failed");
		$fatal(1);
	end

	// Bound checker failures end the run at once
	initial begin
		wait (dut_i.assert_i.failCount != 0);
		$display("Assertion failed in the bound checker at %0t", $time);
		$display("test failed");
		$fatal(1);
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic failRun(input string what);
		$display("%s at %0t", what, $time);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [`CPU_WORD_W-1:0] randomWord();
		logic [31:0] r;
		r = $random(seed);
		return r[`CPU_WORD_W-1:0];
	endfunction

	function automatic rowS makeRow(input cpuBusPkg::addrSelE addrSel,
		input cpuBusPkg::dataSelE dataSel, input logic isByte, input cpuBusPkg::busSeqE seq,
		input logic addrLsb, input logic [2:0] strobes);
		rowS r;
		r.addrSel = addrSel;
		r.dataSel = dataSel;
		r.isByte  = isByte;
		r.seq     = seq;
		r.addrLsb = addrLsb;
		r.strobes = strobes;
		return r;
	endfunction

	function automatic logic [`CPU_WORD_W-1:0] predictAddr(input rowS row);
		case (row.addrSel)
			cpuBusPkg::addrPc:        return datapath.pc;
			cpuBusPkg::addrAluResult: return datapath.aluResult;
			cpuBusPkg::addrAluB:      return datapath.aluB;
			default:                  return datapath.here;
		endcase
	endfunction

	function automatic logic [`CPU_WORD_W-1:0] predictDout(input rowS row);
		logic [`CPU_WORD_W-1:0] src;
		logic [`CPU_WORD_W-1:0] addr;
		src  = (row.dataSel == cpuBusPkg::dataAluResult) ? datapath.aluResult : datapath.regA;
		addr = predictAddr(row);
		if (row.isByte && addr[0]) begin
			return {src[`CPU_BYTE_W-1:0], {`CPU_BYTE_W{1'b0}}};   // Odd byte sits in the high lane
		end
		return src;
	endfunction

	task automatic fillTable();
		stimTable[0]  = makeRow(cpuBusPkg::addrPc, cpuBusPkg::dataRegA, 1'b0,
			cpuBusPkg::seqRead, 1'b0, 3'b011);
		stimTable[1]  = makeRow(cpuBusPkg::addrAluResult, cpuBusPkg::dataAluResult, 1'b0,
			cpuBusPkg::seqWrite, 1'b1, 3'b100);
		stimTable[2]  = makeRow(cpuBusPkg::addrAluB, cpuBusPkg::dataRegA, 1'b0,
			cpuBusPkg::seqWrite, 1'b0, 3'b100);
		stimTable[3]  = makeRow(cpuBusPkg::addrHere, cpuBusPkg::dataAluResult, 1'b0,
			cpuBusPkg::seqRead, 1'b1, 3'b011);
		stimTable[4]  = makeRow(cpuBusPkg::addrPc, cpuBusPkg::dataRegA, 1'b0,
			cpuBusPkg::seqNone, 1'b0, 3'b111);
		stimTable[5]  = makeRow(cpuBusPkg::addrAluResult, cpuBusPkg::dataRegA, 1'b1,
			cpuBusPkg::seqWrite, 1'b0, 3'b101);
		stimTable[6]  = makeRow(cpuBusPkg::addrAluB, cpuBusPkg::dataAluResult, 1'b1,
			cpuBusPkg::seqWrite, 1'b1, 3'b110);
		stimTable[7]  = makeRow(cpuBusPkg::addrHere, cpuBusPkg::dataRegA, 1'b1,
			cpuBusPkg::seqWrite, 1'b1, 3'b110);
		stimTable[8]  = makeRow(cpuBusPkg::addrPc, cpuBusPkg::dataAluResult, 1'b1,
			cpuBusPkg::seqWrite, 1'b0, 3'b101);
		stimTable[9]  = makeRow(cpuBusPkg::addrAluB, cpuBusPkg::dataRegA, 1'b1,
			cpuBusPkg::seqRead, 1'b1, 3'b011);
		stimTable[10] = makeRow(cpuBusPkg::addrHere, cpuBusPkg::dataAluResult, 1'b0,
			cpuBusPkg::seqWrite, 1'b0, 3'b100);
		stimTable[11] = makeRow(cpuBusPkg::addrAluResult, cpuBusPkg::dataRegA, 1'b1,
			cpuBusPkg::seqNone, 1'b1, 3'b111);
	endtask

	// Applied on a falling edge and held until the next commit
	task automatic loadRow(input rowS row);
		cpuBusPkg::datapathS dp;
		dp.pc        = randomWord();
		dp.aluResult = randomWord();
		dp.aluB      = randomWord();
		dp.here      = randomWord();
		dp.regA      = randomWord();
		case (row.addrSel)
			cpuBusPkg::addrPc:        dp.pc[0]        = row.addrLsb;
			cpuBusPkg::addrAluResult: dp.aluResult[0] = row.addrLsb;
			cpuBusPkg::addrAluB:      dp.aluB[0]      = row.addrLsb;
			default:                  dp.here[0]      = row.addrLsb;
		endcase
		datapath    = dp;
		cmd.seq     = row.seq;
		cmd.addrSel = row.addrSel;
		cmd.dataSel = row.dataSel;
		cmd.isByte  = row.isByte;
		din         = randomWord();
	endtask

	task automatic checkIdleStrobes();
		checkValue("mem.rdN", mem.rdN, 1'b1);
		checkValue("mem.wrN0", mem.wrN0, 1'b1);
		checkValue("mem.wrN1", mem.wrN1, 1'b1);
	endtask

	task automatic checkFetch();
		checkValue("phase", phase, cpuBusPkg::phFetch);
		checkValue("mem.addr", mem.addr, datapath.pc);
		checkValue("mem.rdN", mem.rdN, 1'b0);
		checkValue("mem.wrN0", mem.wrN0, 1'b1);
		checkValue("mem.wrN1", mem.wrN1, 1'b1);
		checkValue("pcEn", pcEn, 1'b0);
	endtask

	task automatic checkDecode();
		checkValue("phase", phase, cpuBusPkg::phDecode);
		checkValue("instruction", instruction, din);   // Latched at the end of fetch
		checkValue("mem.addr", mem.addr, datapath.pc);
		checkIdleStrobes();
		checkValue("pcEn", pcEn, 1'b0);
	endtask

	task automatic checkExecute(input rowS row);
		logic [`CPU_WORD_W-1:0] addr;
		addr = predictAddr(row);
		checkValue("phase", phase, cpuBusPkg::phExecute);
		checkValue("mem.addr", mem.addr, addr);
		checkValue("mem.dout", mem.dout, predictDout(row));
		checkValue("mem.highByte", mem.highByte, row.isByte & addr[0]);
		checkIdleStrobes();
		checkValue("pcEn", pcEn, 1'b0);
	endtask

	task automatic checkCommit(input rowS row);
		logic [`CPU_WORD_W-1:0] addr;
		addr = predictAddr(row);
		checkValue("phase", phase, cpuBusPkg::phCommit);
		checkValue("mem.addr", mem.addr, addr);
		checkValue("mem.dout", mem.dout, predictDout(row));
		checkValue("mem.highByte", mem.highByte, row.isByte & addr[0]);
		checkValue("mem.rdN", mem.rdN, row.strobes[2]);
		checkValue("mem.wrN0", mem.wrN0, row.strobes[1]);
		checkValue("mem.wrN1", mem.wrN1, row.strobes[0]);
		checkValue("pcEn", pcEn, 1'b1);
	endtask

	// One req/ack round trip with the core in debug stop
	task automatic runDebugStep();
		int fetches;
		int waited;
		fetches = 0;
		waited  = 0;
		din           = randomWord();
		debug.stepReq = 1'b1;
		do begin
			@(negedge clk);
			waited++;
			if (phase == cpuBusPkg::phFetch) begin
				fetches++;
			end
			if (waited > STEP_LIMIT) begin
				failRun("stepAck did not rise after a step request");
			end
		end while (stepAck !== 1'b1);
		checkValue("fetch count", fetches, 1);
		checkValue("phase", phase, cpuBusPkg::phStopped);
		checkValue("instruction", instruction, din);
		repeat (3) begin   // Core stays put while the request is held
			@(negedge clk);
			checkValue("stepAck", stepAck, 1'b1);
			checkValue("phase", phase, cpuBusPkg::phStopped);
		end
		debug.stepReq = 1'b0;
		@(negedge clk);
		checkValue("stepAck", stepAck, 1'b0);
		checkValue("phase", phase, cpuBusPkg::phStopped);
	endtask

	initial begin
		arstN    = 1'b0;
		halt     = 1'b1;
		debug    = '0;
		din      = '0;
		cmd      = '0;
		datapath = '0;
		fillTable();

		repeat (RESET_CYCLES) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		checkValue("phase", phase, cpuBusPkg::phStopped);
		checkIdleStrobes();
		checkValue("pcEn", pcEn, 1'b0);
		checkValue("stepAck", stepAck, 1'b0);
		checkValue("instruction", instruction, `CPU_RESET_INSTR);

		loadRow(stimTable[0]);
		halt = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			@(negedge clk);
			checkFetch();
			@(negedge clk);
			checkDecode();
			@(negedge clk);
			checkExecute(stimTable[i]);
			@(negedge clk);
			checkCommit(stimTable[i]);
			if (i < NUM_ROWS - 1) begin
				loadRow(stimTable[i + 1]);
			end
		end

		// Halt raised in fetch lets the instruction complete
		@(negedge clk);
		checkFetch();
		halt = 1'b1;
		@(negedge clk);
		checkValue("phase", phase, cpuBusPkg::phDecode);
		@(negedge clk);
		checkValue("phase", phase, cpuBusPkg::phExecute);
		@(negedge clk);
		checkValue("phase", phase, cpuBusPkg::phCommit);
		repeat (HALT_CYCLES - PHASE_COUNT) begin
			@(negedge clk);
			checkValue("stopped", stopped, 1'b1);
			checkValue("phase", phase, cpuBusPkg::phStopped);
			checkIdleStrobes();
		end

		debug.stop = 1'b1;
		halt       = 1'b0;
		@(negedge clk);
		checkValue("debugActive", debugActive, 1'b1);
		checkValue("phase", phase, cpuBusPkg::phStopped);
		@(negedge clk);
		checkValue("phase", phase, cpuBusPkg::phStopped);
		runDebugStep();
		runDebugStep();

		$display("test passed");
		$finish;
	end

endmodule

/* test/cpuBusTop_assert.sv */
`include "cpuBus_macros.svh"

module cpuBusTop_assert (
	input logic                clk,
	input logic                arstN,
	input cpuBusPkg::phaseE    phase,
	input cpuBusPkg::busCmdS   cmd,
	input cpuBusPkg::memBusS   mem,
	input logic                stepAck
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;   // Failed assertions so far

	// Read strobe belongs to fetch and commit only
	rdInPhase: assert property (@(posedge clk) disable iff (!arstN)
		!mem.rdN |-> (phase == cpuBusPkg::phFetch || phase == cpuBusPkg::phCommit))
		else begin
			$error("rdN low in phase %s", phase.name());
			failCount++;
		end

	// Write strobes belong to commit only
	wrInPhase: assert property (@(posedge clk) disable iff (!arstN)
		(!mem.wrN0 || !mem.wrN1) |-> (phase == cpuBusPkg::phCommit))
		else begin
			$error("write strobe low in phase %s", phase.name());
			failCount++;
		end

	// A byte write decided in execute drives a single lane in commit
	byteOneLane: assert property (@(posedge clk) disable iff (!arstN)
		(phase == cpuBusPkg::phExecute && cmd.isByte && cmd.seq == cpuBusPkg::seqWrite)
		|=> (mem.wrN0 || mem.wrN1))
		else begin
			$error("both write lanes low during a byte write");
			failCount++;
		end

	// Ack is only given back with the core stopped
	ackWhenStopped: assert property (@(posedge clk) disable iff (!arstN)
		$rose(stepAck) |-> (phase == cpuBusPkg::phStopped))
		else begin
			$error("stepAck rose in phase %s", phase.name());
			failCount++;
		end

endmodule

// Top level carries the bus and the step handshake together
bind cpuBusTop cpuBusTop_assert assert_i (
	.clk     (clk),
	.arstN   (arstN),
	.phase   (phase),
	.cmd     (cmd),
	.mem     (mem),
	.stepAck (stepAck)
);

/* logic/cpuBusTop.sv */
`include "cpuBus_macros.svh"

module cpuBusTop (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   halt,
	input  cpuBusPkg::debugCtlS    debug,
	input  logic [`CPU_WORD_W-1:0] din,
	input  cpuBusPkg::busCmdS      cmd,
	input  cpuBusPkg::datapathS    datapath,
	output cpuBusPkg::memBusS      mem,
	output logic [`CPU_WORD_W-1:0] instruction,
	output cpuBusPkg::phaseE       phase,
	output logic                   pcEn,
	output logic                   stopped,
	output logic                   debugActive,
	output logic                   stepAck
);

	// Phase is the only control shared by the two blocks
	instructionPhaseDecoder phaseDecoder_i (
		.clk         (clk),
		.arstN       (arstN),
		.halt        (halt),
		.debug       (debug),
		.din         (din),
		.phase       (phase),
		.instruction (instruction),
		.pcEn        (pcEn),
		.stopped     (stopped),
		.debugActive (debugActive),
		.stepAck     (stepAck)
	);

	busController busController_i (
		.clk      (clk),
		.arstN    (arstN),
		.phase    (phase),
		.cmd      (cmd),
		.datapath (datapath),
		.mem      (mem)
	);

endmodule

/* logic/busController.sv */
`include "cpuBus_macros.svh"

module busController (
	input  logic                clk,
	input  logic                arstN,
	input  cpuBusPkg::phaseE    phase,
	input  cpuBusPkg::busCmdS   cmd,
	input  cpuBusPkg::datapathS datapath,
	output cpuBusPkg::memBusS   mem
);

	logic                   busPhase;    // Execute or commit
	cpuBusPkg::addrSelE     addrSel;
	logic [`CPU_WORD_W-1:0] addr;
	logic [`CPU_WORD_W-1:0] srcWord;
	logic                   byteAccess;
	logic                   oddByte;
	logic                   lane0;
	logic                   lane1;
	logic                   isRead;
	logic                   isWrite;
	logic                   rdCommitN;
	logic                   wrN0Q;
	logic                   wrN1Q;

	assign busPhase = (phase == cpuBusPkg::phExecute) || (phase == cpuBusPkg::phCommit);

	// Outside the data phases the bus points at the program counter
	assign addrSel = busPhase ? cmd.addrSel : cpuBusPkg::addrPc;

	always_comb begin
		case (addrSel)
			cpuBusPkg::addrPc:        addr = datapath.pc;
			cpuBusPkg::addrAluResult: addr = datapath.aluResult;
			cpuBusPkg::addrAluB:      addr = datapath.aluB;
			default:                  addr = datapath.here;
		endcase
	end

	assign srcWord = (cmd.dataSel == cpuBusPkg::dataAluResult) ? datapath.aluResult :
		datapath.regA;

	assign byteAccess = busPhase && cmd.isByte;
	assign oddByte    = byteAccess && addr[0];

	// Lane enables, both lanes for a word
	assign lane0 = !cmd.isByte || !addr[0];
	assign lane1 = !cmd.isByte || addr[0];

	assign isRead  = (cmd.seq == cpuBusPkg::seqRead);
	assign isWrite = (cmd.seq == cpuBusPkg::seqWrite);

	// Sampled at the end of execute so the strobes span commit exactly
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdCommitN <= `CPU_STROBE_IDLE;
			wrN0Q     <= `CPU_STROBE_IDLE;
			wrN1Q     <= `CPU_STROBE_IDLE;
		end else if (phase == cpuBusPkg::phExecute) begin
			rdCommitN <= !isRead;
			wrN0Q     <= !(isWrite && lane0);
			wrN1Q     <= !(isWrite && lane1);
		end else begin
			rdCommitN <= `CPU_STROBE_IDLE;
			wrN0Q     <= `CPU_STROBE_IDLE;
			wrN1Q     <= `CPU_STROBE_IDLE;
		end
	end

	always_comb begin
		mem.addr = addr;
		if (oddByte) begin
			// Low byte of the source moves up to the high lane
			mem.dout = {srcWord[`CPU_BYTE_W-1:0], {`CPU_BYTE_W{1'b0}}};
		end else begin
			mem.dout = srcWord;
		end
		// Fetch read comes straight off the dedicated fetch phase bit
		mem.rdN      = rdCommitN && (phase != cpuBusPkg::phFetch);
		mem.wrN0     = wrN0Q;
		mem.wrN1     = wrN1Q;
		mem.highByte = oddByte;
	end

endmodule

/* logic/instructionPhaseDecoder.sv */
`include "cpuBus_macros.svh"

module instructionPhaseDecoder (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   halt,
	input  cpuBusPkg::debugCtlS    debug,
	input  logic [`CPU_WORD_W-1:0] din,
	output cpuBusPkg::phaseE       phase,
	output logic [`CPU_WORD_W-1:0] instruction,
	output logic                   pcEn,
	output logic                   stopped,
	output logic                   debugActive,
	output logic                   stepAck
);

	cpuBusPkg::phaseE phaseNext;
	logic             debugNext;
	logic             stepPending;   // One instruction granted to the debugger
	logic             stepStart;
	logic             stepDone;

	// A step only launches from a clean debug stop with the handshake idle
	assign stepStart = (phase == cpuBusPkg::phStopped) && debugActive && debug.stop &&
		!halt && debug.stepReq && !stepAck && !stepPending;

	assign stepDone = stepPending && (phase == cpuBusPkg::phCommit);

	always_comb begin
		phaseNext = phase;
		debugNext = debugActive;
		case (phase)
			cpuBusPkg::phFetch: begin
				phaseNext = cpuBusPkg::phDecode;
			end
			cpuBusPkg::phDecode: begin
				phaseNext = cpuBusPkg::phExecute;
			end
			cpuBusPkg::phExecute: begin
				phaseNext = cpuBusPkg::phCommit;
			end
			default: begin   // Stopped or end of commit
				if (halt) begin
					phaseNext = cpuBusPkg::phStopped;
					debugNext = 1'b0;
				end else if (debug.stop) begin
					phaseNext = stepStart ? cpuBusPkg::phFetch : cpuBusPkg::phStopped;
					debugNext = 1'b1;
				end else begin
					phaseNext = cpuBusPkg::phFetch;
					debugNext = 1'b0;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			phase       <= cpuBusPkg::phStopped;
			debugActive <= 1'b0;
		end else begin
			phase       <= phaseNext;
			debugActive <= debugNext;
		end
	end

	// Pending flag covers the fetch through commit of the granted step
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stepPending <= 1'b0;
		end else if (stepStart) begin
			stepPending <= 1'b1;
		end else if (stepDone) begin
			stepPending <= 1'b0;
		end
	end

	// Four-phase ack, rises on re-entry to stopped, drops after req falls
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stepAck <= 1'b0;
		end else if (stepDone) begin
			stepAck <= 1'b1;
		end else if (!debug.stepReq) begin
			stepAck <= 1'b0;
		end
	end

	// Instruction word is on din for the whole fetch cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instruction <= `CPU_RESET_INSTR;
		end else if (phase == cpuBusPkg::phFetch) begin
			instruction <= din;
		end
	end

	assign pcEn    = (phase == cpuBusPkg::phCommit);
	assign stopped = (phase == cpuBusPkg::phStopped);

endmodule

/* logic/cpuBusPkg.sv */
`include "cpuBus_macros.svh"

package cpuBusPkg;

	// Fetch owns bit 2 alone, so the fetch read strobe decodes from one flop
	typedef enum logic [2:0] {
		phStopped = 3'b000,
		phFetch   = 3'b100,
		phDecode  = 3'b001,
		phExecute = 3'b011,
		phCommit  = 3'b010
	} phaseE;

	typedef enum logic [1:0] {
		seqNone  = 2'b00,
		seqRead  = 2'b01,
		seqWrite = 2'b10
	} busSeqE;

	typedef enum logic [1:0] {
		addrPc        = 2'b00,
		addrAluResult = 2'b01,
		addrAluB      = 2'b10,
		addrHere      = 2'b11
	} addrSelE;

	typedef enum logic {
		dataRegA      = 1'b0,
		dataAluResult = 1'b1
	} dataSelE;

	typedef struct packed {
		busSeqE  seq;
		addrSelE addrSel;
		dataSelE dataSel;
		logic    isByte;   // Single lane access
	} busCmdS;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] pc;
		logic [`CPU_WORD_W-1:0] aluResult;
		logic [`CPU_WORD_W-1:0] aluB;
		logic [`CPU_WORD_W-1:0] here;
		logic [`CPU_WORD_W-1:0] regA;
	} datapathS;

	typedef struct packed {
		logic stop;
		logic stepReq;
	} debugCtlS;

	typedef struct packed {
		logic [`CPU_WORD_W-1:0] addr;
		logic [`CPU_WORD_W-1:0] dout;
		logic                   rdN;
		logic                   wrN0;      // Low lane write strobe
		logic                   wrN1;      // High lane write strobe
		logic                   highByte;
	} memBusS;

endpackage

/* include/cpuBus_macros.svh */
`ifndef CPU_BUS_MACROS_SVH
`define CPU_BUS_MACROS_SVH

// Word and address width of the instruction set
`define CPU_WORD_W 16

// One byte lane on the memory bus
`define CPU_BYTE_W 8

// Number of byte lanes in a word
`define CPU_LANES (`CPU_WORD_W / `CPU_BYTE_W)

// Instruction register contents after reset
`define CPU_RESET_INSTR {`CPU_WORD_W{1'b0}}

// Inactive level of the active-low memory strobes
`define CPU_STROBE_IDLE 1'b1

`endif
